// ==== hw/rx_stats_pkg.sv ====
package rx_stats_pkg;

    // stream and bus widths
    localparam int FLIT_W  = 512;
    localparam int EMPTY_W = 6;
    localparam int CNT_W   = 32;
    localparam int REG_AW  = 8;

    // locally administered source, packets from it never reach the output
    localparam logic [47:0] SRC_MAC_FILTER = 48'h0a1b2c3d4e5f;

    // returned for any unmapped offset
    localparam logic [CNT_W-1:0] READ_DEFAULT = 32'h123;

    ////////////////////
    // register map
    ////////////////////
    localparam logic [REG_AW-1:0] REG_SCRATCH     = 8'd0;
    localparam logic [REG_AW-1:0] REG_CTRL        = 8'd1;
    localparam logic [REG_AW-1:0] REG_DONE        = 8'd2;
    localparam logic [REG_AW-1:0] REG_CYCLE       = 8'd4;
    localparam logic [REG_AW-1:0] REG_FLIT        = 8'd5;
    localparam logic [REG_AW-1:0] REG_PKT         = 8'd6;
    localparam logic [REG_AW-1:0] REG_MAX_PKT     = 8'd9;
    localparam logic [REG_AW-1:0] REG_WARMUP      = 8'd10;
    localparam logic [REG_AW-1:0] REG_PKT_CNT     = 8'd11;
    localparam logic [REG_AW-1:0] REG_OUT_PKT_CNT = 8'd12;
    localparam logic [REG_AW-1:0] REG_IN_PKT_CNT  = 8'd13;

    // header fields of a start flit, top bits first
    typedef struct packed {
        logic [47:0]  upper;
        logic [47:0]  src_mac;
        logic [415:0] rest;
    } flit_hdr_s;

    // raw view is forwarded, header view feeds the filter
    typedef union packed {
        logic [FLIT_W-1:0] raw;
        flit_hdr_s         hdr;
    } flit_u;

endpackage

// ==== hw/rx_src_filter.sv ====
`timescale 1ns/1ns

module rx_src_filter import rx_stats_pkg::*; (
    input  logic               clk_rx,
    input  logic               i_rst,
    input  logic               i_rx_valid,
    input  logic               i_rx_sop,
    input  logic               i_rx_eop,
    input  logic [EMPTY_W-1:0] i_rx_empty,
    input  flit_u              i_rx_data,
    input  logic               i_clear,
    output logic               o_valid,
    output logic               o_sop,
    output logic               o_eop,
    output logic [EMPTY_W-1:0] o_empty,
    output flit_u              o_data,
    output logic [CNT_W-1:0]   o_in_pkt_cnt
);

    // source field matches the filter address
    logic mac_match;
    // set while the body of a dropped packet is still arriving
    logic drop_rest;

    assign mac_match = (i_rx_data.hdr.src_mac == SRC_MAC_FILTER);

    ////////////////////
    // control strobes and drop decision
    ////////////////////
    always_ff @(posedge clk_rx) begin
        if (i_rst || i_clear) begin
            o_valid   <= 1'b0;
            o_sop     <= 1'b0;
            o_eop     <= 1'b0;
            o_empty   <= '0;
            drop_rest <= 1'b0;
        end else begin
            o_sop   <= i_rx_sop;
            o_eop   <= i_rx_eop;
            o_empty <= i_rx_empty;
            if (!i_rx_valid) begin
                // idle cycle
                o_valid <= 1'b0;
            end else if (i_rx_sop) begin
                // start flit decides the fate of the whole packet
                o_valid   <= !mac_match;
                drop_rest <= mac_match && !i_rx_eop;
            end else begin
                // body flit follows the start flit
                o_valid <= !drop_rest;
                if (i_rx_eop) begin
                    drop_rest <= 1'b0;
                end
            end
        end
    end

    // payload is registered unconditionally
    always_ff @(posedge clk_rx) begin
        o_data <= i_rx_data;
    end

    // raw packets seen at the tap whether filtered or not
    always_ff @(posedge clk_rx) begin
        if (i_rst) begin
            o_in_pkt_cnt <= '0;
        end else if (i_rx_valid && i_rx_eop) begin
            o_in_pkt_cnt <= o_in_pkt_cnt + 1'b1;
        end
    end

    // a kept flit needs a valid input sampled outside a flush
    a_clear_kills_valid: assert property (
        @(posedge clk_rx) disable iff (i_rst) o_valid |-> $past(i_rx_valid && !i_clear)
    );

endmodule

// ==== hw/rx_fwd_delay.sv ====
`timescale 1ns/1ns

module rx_fwd_delay import rx_stats_pkg::*; (
    input  logic               clk_rx,
    input  logic               i_rst,
    input  logic               i_valid,
    input  logic               i_sop,
    input  logic               i_eop,
    input  logic [EMPTY_W-1:0] i_empty,
    input  flit_u              i_data,
    input  logic               i_clear,
    output logic               o_rx_valid,
    output logic               o_rx_sop,
    output logic               o_rx_eop,
    output logic [EMPTY_W-1:0] o_rx_empty,
    output logic [FLIT_W-1:0]  o_rx_data,
    output logic [CNT_W-1:0]   o_out_pkt_cnt
);

    // middle stage
    logic               s1_valid;
    logic               s1_sop;
    logic               s1_eop;
    logic [EMPTY_W-1:0] s1_empty;
    flit_u              s1_data;

    // strobes flush on clear
    always_ff @(posedge clk_rx) begin
        if (i_rst || i_clear) begin
            s1_valid   <= 1'b0;
            s1_sop     <= 1'b0;
            s1_eop     <= 1'b0;
            s1_empty   <= '0;
            o_rx_valid <= 1'b0;
            o_rx_sop   <= 1'b0;
            o_rx_eop   <= 1'b0;
            o_rx_empty <= '0;
        end else begin
            s1_valid   <= i_valid;
            s1_sop     <= i_sop;
            s1_eop     <= i_eop;
            s1_empty   <= i_empty;
            o_rx_valid <= s1_valid;
            o_rx_sop   <= s1_sop;
            o_rx_eop   <= s1_eop;
            o_rx_empty <= s1_empty;
        end
    end

    // payload pipe, untouched
    always_ff @(posedge clk_rx) begin
        s1_data   <= i_data;
        o_rx_data <= s1_data.raw;
    end

    // packets actually delivered downstream
    always_ff @(posedge clk_rx) begin
        if (i_rst) begin
            o_out_pkt_cnt <= '0;
        end else if (o_rx_valid && o_rx_eop) begin
            o_out_pkt_cnt <= o_out_pkt_cnt + 1'b1;
        end
    end

    // two-cycle latency holds when no flush intervenes
    a_two_stage_valid: assert property (
        @(posedge clk_rx) disable iff (i_rst)
        (!i_clear ##1 !i_clear) |=> (o_rx_valid == $past(i_valid, 2))
    );

endmodule

// ==== hw/rx_window_stats.sv ====
`timescale 1ns/1ns

module rx_window_stats import rx_stats_pkg::*; (
    input  logic             clk_rx,
    input  logic             i_rst,
    input  logic             i_valid,
    input  logic             i_eop,
    input  logic             i_clear,
    input  logic [CNT_W-1:0] i_warmup,
    input  logic [CNT_W-1:0] i_max_pkt,
    output logic [CNT_W-1:0] o_done,
    output logic [CNT_W-1:0] o_cycle,
    output logic [CNT_W-1:0] o_flit,
    output logic [CNT_W-1:0] o_pkt,
    output logic [CNT_W-1:0] o_pkt_cnt
);

    // packet count past warm-up and not beyond maximum
    logic in_window;
    // registered copy of in_window
    logic busy;
    // kept flit that closes a packet
    logic kept_eop;

    assign in_window = (o_pkt_cnt > i_warmup) && (o_pkt_cnt <= i_max_pkt);
    assign kept_eop  = i_valid && i_eop;

    ////////////////////
    // window counters
    ////////////////////
    always_ff @(posedge clk_rx) begin
        if (i_rst || i_clear) begin
            busy      <= 1'b0;
            o_done    <= '0;
            o_cycle   <= '0;
            o_flit    <= '0;
            o_pkt     <= '0;
            o_pkt_cnt <= '0;
        end else begin
            busy <= in_window;

            // flits and packets only inside the window
            if (in_window && i_valid) begin
                o_flit <= o_flit + 1'b1;
                if (i_eop) begin
                    o_pkt <= o_pkt + 1'b1;
                end
            end

            // sticky done once maximum is hit
            if ((o_pkt_cnt == i_max_pkt) && (i_max_pkt != '0)) begin
                o_done <= 32'd1;
            end

            // busy lags the window by one cycle
            if (busy) begin
                o_cycle <= o_cycle + 1'b1;
            end

            // every surviving packet
            if (kept_eop) begin
                o_pkt_cnt <= o_pkt_cnt + 1'b1;
            end
        end
    end

    // a packet can only be counted together with its last flit
    a_pkt_le_flit: assert property (
        @(posedge clk_rx) disable iff (i_rst) o_pkt <= o_flit
    );

endmodule

// ==== hw/rx_status_regs.sv ====
`timescale 1ns/1ns

module rx_status_regs import rx_stats_pkg::*; (
    input  logic              clk_rx,
    input  logic              i_rst,
    input  logic [REG_AW-1:0] i_status_addr,
    input  logic              i_status_read,
    input  logic              i_status_write,
    input  logic [CNT_W-1:0]  i_status_writedata,
    input  logic [CNT_W-1:0]  i_done,
    input  logic [CNT_W-1:0]  i_cycle,
    input  logic [CNT_W-1:0]  i_flit,
    input  logic [CNT_W-1:0]  i_pkt,
    input  logic [CNT_W-1:0]  i_pkt_cnt,
    input  logic [CNT_W-1:0]  i_out_pkt_cnt,
    input  logic [CNT_W-1:0]  i_in_pkt_cnt,
    output logic [CNT_W-1:0]  o_status_readdata,
    output logic              o_status_readdata_valid,
    output logic              o_clear,
    output logic [CNT_W-1:0]  o_warmup,
    output logic [CNT_W-1:0]  o_max_pkt
);

    // bus strobes, one register stage
    logic [REG_AW-1:0] addr_r;
    logic              read_r;
    logic              write_r;
    logic [CNT_W-1:0]  writedata_r;

    // writable registers
    logic [CNT_W-1:0]  scratch;
    logic [CNT_W-1:0]  reg_ctrl;

    // bit 0 is a level, held until software drops it
    assign o_clear = reg_ctrl[0];

    always_ff @(posedge clk_rx) begin
        if (i_rst) begin
            addr_r      <= '0;
            read_r      <= 1'b0;
            write_r     <= 1'b0;
            writedata_r <= '0;
        end else begin
            addr_r      <= i_status_addr;
            read_r      <= i_status_read;
            write_r     <= i_status_write;
            writedata_r <= i_status_writedata;
        end
    end

    ////////////////////
    // write decode
    ////////////////////
    always_ff @(posedge clk_rx) begin
        if (i_rst) begin
            scratch   <= '0;
            reg_ctrl  <= '0;
            o_max_pkt <= '0;
            o_warmup  <= '0;
        end else begin
            if (write_r) begin
                case (addr_r)
                    REG_SCRATCH: scratch   <= writedata_r;
                    REG_CTRL:    reg_ctrl  <= writedata_r;
                    REG_MAX_PKT: o_max_pkt <= writedata_r;
                    REG_WARMUP:  o_warmup  <= writedata_r;
                    default: ;
                endcase
            end
            // clear wins over a same-cycle write
            if (o_clear) begin
                scratch   <= '0;
                o_max_pkt <= '0;
                o_warmup  <= '0;
            end
        end
    end

    ////////////////////
    // read mux
    ////////////////////
    always_ff @(posedge clk_rx) begin
        if (i_rst) begin
            o_status_readdata       <= '0;
            o_status_readdata_valid <= 1'b0;
        end else begin
            // one-cycle pulse per read strobe
            o_status_readdata_valid <= read_r;
            if (read_r) begin
                case (addr_r)
                    REG_SCRATCH:     o_status_readdata <= scratch;
                    REG_CTRL:        o_status_readdata <= reg_ctrl;
                    REG_DONE:        o_status_readdata <= i_done;
                    REG_CYCLE:       o_status_readdata <= i_cycle;
                    REG_FLIT:        o_status_readdata <= i_flit;
                    REG_PKT:         o_status_readdata <= i_pkt;
                    REG_MAX_PKT:     o_status_readdata <= o_max_pkt;
                    REG_WARMUP:      o_status_readdata <= o_warmup;
                    REG_PKT_CNT:     o_status_readdata <= i_pkt_cnt;
                    REG_OUT_PKT_CNT: o_status_readdata <= i_out_pkt_cnt;
                    REG_IN_PKT_CNT:  o_status_readdata <= i_in_pkt_cnt;
                    default:         o_status_readdata <= READ_DEFAULT;
                endcase
            end
        end
    end

    // read response always lands two edges after the strobe
    a_read_latency: assert property (
        @(posedge clk_rx) disable iff (i_rst) i_status_read |-> ##2 o_status_readdata_valid
    );

endmodule

// ==== hw/rx_stats_top.sv ====
`timescale 1ns/1ns

module rx_stats_top import rx_stats_pkg::*; (
    input  logic               clk_rx,
    input  logic               i_rst,
    // receive stream in
    input  logic               i_rx_valid,
    input  logic               i_rx_sop,
    input  logic               i_rx_eop,
    input  logic [EMPTY_W-1:0] i_rx_empty,
    input  logic [FLIT_W-1:0]  i_rx_data,
    // forwarded stream out
    output logic               o_rx_valid,
    output logic               o_rx_sop,
    output logic               o_rx_eop,
    output logic [EMPTY_W-1:0] o_rx_empty,
    output logic [FLIT_W-1:0]  o_rx_data,
    // status register bus
    input  logic [REG_AW-1:0]  i_status_addr,
    input  logic               i_status_read,
    input  logic               i_status_write,
    input  logic [CNT_W-1:0]   i_status_writedata,
    output logic [CNT_W-1:0]   o_status_readdata,
    output logic               o_status_readdata_valid
);

    // filter stage outputs
    logic               f_valid;
    logic               f_sop;
    logic               f_eop;
    logic [EMPTY_W-1:0] f_empty;
    flit_u              f_data;

    // control from the register block
    logic               clear;
    logic [CNT_W-1:0]   warmup;
    logic [CNT_W-1:0]   max_pkt;

    // counters back to the register block
    logic [CNT_W-1:0]   done;
    logic [CNT_W-1:0]   cycle_cnt;
    logic [CNT_W-1:0]   flit_cnt;
    logic [CNT_W-1:0]   pkt;
    logic [CNT_W-1:0]   pkt_cnt;
    logic [CNT_W-1:0]   in_pkt_cnt;
    logic [CNT_W-1:0]   out_pkt_cnt;

    rx_src_filter rx_src_filter_inst (
        .clk_rx       (clk_rx),
        .i_rst        (i_rst),
        .i_rx_valid   (i_rx_valid),
        .i_rx_sop     (i_rx_sop),
        .i_rx_eop     (i_rx_eop),
        .i_rx_empty   (i_rx_empty),
        .i_rx_data    (i_rx_data),
        .i_clear      (clear),
        .o_valid      (f_valid),
        .o_sop        (f_sop),
        .o_eop        (f_eop),
        .o_empty      (f_empty),
        .o_data       (f_data),
        .o_in_pkt_cnt (in_pkt_cnt)
    );

    rx_fwd_delay rx_fwd_delay_inst (
        .clk_rx        (clk_rx),
        .i_rst         (i_rst),
        .i_valid       (f_valid),
        .i_sop         (f_sop),
        .i_eop         (f_eop),
        .i_empty       (f_empty),
        .i_data        (f_data),
        .i_clear       (clear),
        .o_rx_valid    (o_rx_valid),
        .o_rx_sop      (o_rx_sop),
        .o_rx_eop      (o_rx_eop),
        .o_rx_empty    (o_rx_empty),
        .o_rx_data     (o_rx_data),
        .o_out_pkt_cnt (out_pkt_cnt)
    );

    rx_window_stats rx_window_stats_inst (
        .clk_rx    (clk_rx),
        .i_rst     (i_rst),
        .i_valid   (f_valid),
        .i_eop     (f_eop),
        .i_clear   (clear),
        .i_warmup  (warmup),
        .i_max_pkt (max_pkt),
        .o_done    (done),
        .o_cycle   (cycle_cnt),
        .o_flit    (flit_cnt),
        .o_pkt     (pkt),
        .o_pkt_cnt (pkt_cnt)
    );

    rx_status_regs rx_status_regs_inst (
        .clk_rx                  (clk_rx),
        .i_rst                   (i_rst),
        .i_status_addr           (i_status_addr),
        .i_status_read           (i_status_read),
        .i_status_write          (i_status_write),
        .i_status_writedata      (i_status_writedata),
        .i_done                  (done),
        .i_cycle                 (cycle_cnt),
        .i_flit                  (flit_cnt),
        .i_pkt                   (pkt),
        .i_pkt_cnt               (pkt_cnt),
        .i_out_pkt_cnt           (out_pkt_cnt),
        .i_in_pkt_cnt            (in_pkt_cnt),
        .o_status_readdata       (o_status_readdata),
        .o_status_readdata_valid (o_status_readdata_valid),
        .o_clear                 (clear),
        .o_warmup                (warmup),
        .o_max_pkt               (max_pkt)
    );

endmodule

// ==== bench/tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen (
    output logic o_clk
);

    // 8 ns period
    initial begin
        o_clk = 1'b0;
        forever begin
            #4 o_clk = ~o_clk;
        end
    end

endmodule

// ==== bench/tb_rx_stats.sv ====
`timescale 1ns/1ns

module tb_rx_stats import rx_stats_pkg::*; ();

    localparam int NUM_PKTS       = 60;
    // up to 4 flits plus up to 2 idle cycles
    localparam int PKT_MAX_CYCLES = 6;
    // 14 writes and 30 reads
    localparam int BUS_OPS        = 44;
    localparam int BUS_OP_CYCLES  = 4;
    localparam int TIMEOUT_CYCLES = 2 * (NUM_PKTS * PKT_MAX_CYCLES + BUS_OPS * BUS_OP_CYCLES);

    logic               clk_rx;
    logic               i_rst;
    logic               i_rx_valid;
    logic               i_rx_sop;
    logic               i_rx_eop;
    logic [EMPTY_W-1:0] i_rx_empty;
    logic [FLIT_W-1:0]  i_rx_data;
    logic               o_rx_valid;
    logic               o_rx_sop;
    logic               o_rx_eop;
    logic [EMPTY_W-1:0] o_rx_empty;
    logic [FLIT_W-1:0]  o_rx_data;
    logic [REG_AW-1:0]  i_status_addr;
    logic               i_status_read;
    logic               i_status_write;
    logic [CNT_W-1:0]   i_status_writedata;
    logic [CNT_W-1:0]   o_status_readdata;
    logic               o_status_readdata_valid;

    integer seed;
    int     cyc = 0;
    int     wd_cnt = 0;

    // model state for bus registers and window counters
    logic [CNT_W-1:0] m_scratch = '0;
    logic [CNT_W-1:0] m_ctrl = '0;
    logic [CNT_W-1:0] m_max = '0;
    logic [CNT_W-1:0] m_warmup = '0;
    logic             m_f_valid;
    logic             m_f_eop;
    logic             m_drop;
    logic             m_busy;
    logic [CNT_W-1:0] m_done;
    logic [CNT_W-1:0] m_cycle;
    logic [CNT_W-1:0] m_flit;
    logic [CNT_W-1:0] m_pkt;
    logic [CNT_W-1:0] m_pkt_cnt;
    logic [CNT_W-1:0] m_in_cnt;
    logic [CNT_W-1:0] m_out_cnt;

    // kept flits waiting for the output
    // ctl holds {sop, eop, empty}
    logic [FLIT_W-1:0]  exp_data_q[$];
    logic [EMPTY_W+1:0] exp_ctl_q[$];
    int                 exp_cyc_q[$];

    tb_clkgen tb_clkgen_inst (.o_clk(clk_rx));

    rx_stats_top rx_stats_top_inst (
        .clk_rx                  (clk_rx),
        .i_rst                   (i_rst),
        .i_rx_valid              (i_rx_valid),
        .i_rx_sop                (i_rx_sop),
        .i_rx_eop                (i_rx_eop),
        .i_rx_empty              (i_rx_empty),
        .i_rx_data               (i_rx_data),
        .o_rx_valid              (o_rx_valid),
        .o_rx_sop                (o_rx_sop),
        .o_rx_eop                (o_rx_eop),
        .o_rx_empty              (o_rx_empty),
        .o_rx_data               (o_rx_data),
        .i_status_addr           (i_status_addr),
        .i_status_read           (i_status_read),
        .i_status_write          (i_status_write),
        .i_status_writedata      (i_status_writedata),
        .o_status_readdata       (o_status_readdata),
        .o_status_readdata_valid (o_status_readdata_valid)
    );

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [FLIT_W-1:0] got,
                               input logic [FLIT_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // register value the DUT should return for an offset
    function automatic logic [CNT_W-1:0] model_reg(input logic [REG_AW-1:0] addr);
        case (addr)
            REG_SCRATCH:     return m_scratch;
            REG_CTRL:        return m_ctrl;
            REG_DONE:        return m_done;
            REG_CYCLE:       return m_cycle;
            REG_FLIT:        return m_flit;
            REG_PKT:         return m_pkt;
            REG_MAX_PKT:     return m_max;
            REG_WARMUP:      return m_warmup;
            REG_PKT_CNT:     return m_pkt_cnt;
            REG_OUT_PKT_CNT: return m_out_cnt;
            REG_IN_PKT_CNT:  return m_in_cnt;
            default:         return READ_DEFAULT;
        endcase
    endfunction

    ////////////////////
    // stimulus tasks
    ////////////////////
    task automatic drive_flit(input logic v, input logic s, input logic e,
                              input logic [EMPTY_W-1:0] em, input logic [FLIT_W-1:0] d);
        @(posedge clk_rx);
        #1;
        i_rx_valid = v;
        i_rx_sop   = s;
        i_rx_eop   = e;
        i_rx_empty = em;
        i_rx_data  = d;
    endtask

    // strobe sampled one edge later and register updated on the next
    task automatic bus_write(input logic [REG_AW-1:0] addr, input logic [CNT_W-1:0] data);
        @(posedge clk_rx);
        #1;
        i_status_write     = 1'b1;
        i_status_addr      = addr;
        i_status_writedata = data;
        @(posedge clk_rx);
        #1;
        i_status_write = 1'b0;
        @(posedge clk_rx);
        #1;
        case (addr)
            REG_SCRATCH: m_scratch = data;
            REG_CTRL:    m_ctrl = data;
            REG_MAX_PKT: m_max = data;
            REG_WARMUP:  m_warmup = data;
            default: ;
        endcase
        // clear level zeroes the writable registers
        if (m_ctrl[0]) begin
            m_scratch = '0;
            m_max     = '0;
            m_warmup  = '0;
        end
    endtask

    // read data expected two edges after the strobe and valid for one cycle
    task automatic read_check(input logic [REG_AW-1:0] addr, input string name);
        logic [CNT_W-1:0] exp;
        @(posedge clk_rx);
        #1;
        i_status_read = 1'b1;
        i_status_addr = addr;
        @(posedge clk_rx);
        #1;
        i_status_read = 1'b0;
        // counters sampled by the read mux on the next edge
        exp = model_reg(addr);
        check_value("o_status_readdata_valid", o_status_readdata_valid, 0);
        @(posedge clk_rx);
        #1;
        check_value("o_status_readdata_valid", o_status_readdata_valid, 1);
        check_value(name, o_status_readdata, exp);
        @(posedge clk_rx);
        #1;
        check_value("o_status_readdata_valid", o_status_readdata_valid, 0);
    endtask

    task automatic send_traffic(input int n_pkts);
        logic [FLIT_W-1:0]  d;
        logic [EMPTY_W-1:0] em;
        int                 len;
        int                 gap;
        logic               bad_src;
        for (int p = 0; p < n_pkts; p++) begin
            len     = 1 + $unsigned($random(seed)) % 4;
            bad_src = ($unsigned($random(seed)) % 4) == 0;
            for (int f = 0; f < len; f++) begin
                for (int w = 0; w < FLIT_W / 32; w++) begin
                    d[w*32 +: 32] = $random(seed);
                end
                // src_mac sits at bits 463:416 of a start flit
                if (f == 0 && bad_src) begin
                    d[463:416] = SRC_MAC_FILTER;
                end
                em = (f == len - 1) ? EMPTY_W'($random(seed)) : '0;
                drive_flit(1'b1, f == 0, f == len - 1, em, d);
            end
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) drive_flit(1'b0, 1'b0, 1'b0, '0, '0);
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////
    always @(posedge clk_rx) begin : filter_model
        logic keep;
        logic in_win;
        cyc    = cyc + 1;
        keep   = 1'b0;
        in_win = (m_pkt_cnt > m_warmup) && (m_pkt_cnt <= m_max);
        // raw and delivered packet counts cleared by reset only
        if (i_rst) begin
            m_in_cnt  <= '0;
            m_out_cnt <= '0;
        end else begin
            if (i_rx_valid && i_rx_eop) m_in_cnt <= m_in_cnt + 1;
            if (m_f_valid && m_f_eop) m_out_cnt <= m_out_cnt + 1;
        end
        if (i_rst || m_ctrl[0]) begin
            m_f_valid <= 1'b0;
            m_f_eop   <= 1'b0;
            m_drop    <= 1'b0;
            m_busy    <= 1'b0;
            m_done    <= '0;
            m_cycle   <= '0;
            m_flit    <= '0;
            m_pkt     <= '0;
            m_pkt_cnt <= '0;
        end else begin
            if (i_rx_valid && i_rx_sop) begin
                keep = (i_rx_data[463:416] != SRC_MAC_FILTER);
                m_drop <= !keep && !i_rx_eop;
            end else if (i_rx_valid) begin
                keep = !m_drop;
                if (i_rx_eop) m_drop <= 1'b0;
            end
            m_f_valid <= keep;
            m_f_eop   <= i_rx_eop;
            if (keep) begin
                exp_data_q.push_back(i_rx_data);
                exp_ctl_q.push_back({i_rx_sop, i_rx_eop, i_rx_empty});
                exp_cyc_q.push_back(cyc);
            end
            // window counters watch the kept stream one stage later
            m_busy <= in_win;
            if (in_win && m_f_valid) m_flit <= m_flit + 1;
            if (in_win && m_f_valid && m_f_eop) m_pkt <= m_pkt + 1;
            if (m_pkt_cnt == m_max && m_max != 0) m_done <= 1;
            if (m_busy) m_cycle <= m_cycle + 1;
            if (m_f_valid && m_f_eop) m_pkt_cnt <= m_pkt_cnt + 1;
        end
    end

    // outputs compared mid-cycle away from the edges
    always @(negedge clk_rx) begin : out_monitor
        logic [EMPTY_W+1:0] ctl;
        int                 tag;
        if (!i_rst && o_rx_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("output flit appeared while no kept flit was pending");
                abort_run();
            end else begin
                ctl = exp_ctl_q.pop_front();
                tag = exp_cyc_q.pop_front();
                check_value("o_rx_data", o_rx_data, exp_data_q.pop_front());
                check_value("o_rx_sop", o_rx_sop, ctl[EMPTY_W+1]);
                check_value("o_rx_eop", o_rx_eop, ctl[EMPTY_W]);
                check_value("o_rx_empty", o_rx_empty, ctl[EMPTY_W-1:0]);
                // sampled at edge n and shown after edge n+2
                check_value("o_rx flit latency", cyc - tag, 2);
            end
        end
    end

    always @(posedge clk_rx) begin
        wd_cnt <= wd_cnt + 1;
        if (wd_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin
        logic [CNT_W-1:0] warm;
        seed               = 32'h2309840f;
        i_rst              = 1'b1;
        i_rx_valid         = 1'b0;
        i_rx_sop           = 1'b0;
        i_rx_eop           = 1'b0;
        i_rx_empty         = '0;
        i_rx_data          = '0;
        i_status_addr      = '0;
        i_status_read      = 1'b0;
        i_status_write     = 1'b0;
        i_status_writedata = '0;
        repeat (3) @(posedge clk_rx);
        #1;
        i_rst = 1'b0;

        // quiet after reset with done clear and unmapped reads at default
        check_value("o_rx_valid", o_rx_valid, 0);
        check_value("o_status_readdata_valid", o_status_readdata_valid, 0);
        read_check(REG_DONE, "REG_DONE");
        read_check(8'd3, "unmapped 0x03");
        read_check(8'hc7, "unmapped 0xc7");

        // writable registers read back
        repeat (3) begin
            bus_write(REG_SCRATCH, $random(seed));
            bus_write(REG_MAX_PKT, $random(seed));
            bus_write(REG_WARMUP, $random(seed));
            read_check(REG_SCRATCH, "REG_SCRATCH");
            read_check(REG_MAX_PKT, "REG_MAX_PKT");
            read_check(REG_WARMUP, "REG_WARMUP");
        end

        ////////////////////
        // window run
        ////////////////////
        warm = 1 + $unsigned($random(seed)) % 4;
        bus_write(REG_WARMUP, warm);
        bus_write(REG_MAX_PKT, warm + 5 + $unsigned($random(seed)) % 8);
        send_traffic(NUM_PKTS);
        // let the pipe drain
        repeat (8) drive_flit(1'b0, 1'b0, 1'b0, '0, '0);
        read_check(REG_FLIT, "REG_FLIT");
        read_check(REG_PKT, "REG_PKT");
        read_check(REG_CYCLE, "REG_CYCLE");
        read_check(REG_PKT_CNT, "REG_PKT_CNT");
        read_check(REG_DONE, "REG_DONE");
        read_check(REG_IN_PKT_CNT, "REG_IN_PKT_CNT");
        read_check(REG_OUT_PKT_CNT, "REG_OUT_PKT_CNT");

        // clear pulse that packet counts survive
        bus_write(REG_SCRATCH, $random(seed));
        bus_write(REG_CTRL, 32'd1);
        read_check(REG_CTRL, "REG_CTRL");
        bus_write(REG_CTRL, 32'd0);
        read_check(REG_FLIT, "REG_FLIT");
        read_check(REG_PKT, "REG_PKT");
        read_check(REG_CYCLE, "REG_CYCLE");
        read_check(REG_PKT_CNT, "REG_PKT_CNT");
        read_check(REG_DONE, "REG_DONE");
        read_check(REG_SCRATCH, "REG_SCRATCH");
        read_check(REG_MAX_PKT, "REG_MAX_PKT");
        read_check(REG_WARMUP, "REG_WARMUP");
        read_check(REG_IN_PKT_CNT, "REG_IN_PKT_CNT");
        read_check(REG_OUT_PKT_CNT, "REG_OUT_PKT_CNT");

        if (exp_data_q.size() != 0) begin
            $display("%0d kept flits never reached the output", exp_data_q.size());
            abort_run();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
hw/rx_stats_pkg.sv
hw/rx_src_filter.sv
hw/rx_fwd_delay.sv
hw/rx_window_stats.sv
hw/rx_status_regs.sv
hw/rx_stats_top.sv
bench/tb_clkgen.sv
bench/tb_rx_stats.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_rx_stats \
    -f tb.f -o vtb_rx_stats || { echo "build failed"; exit 1; }
out="$(./obj_dir/vtb_rx_stats 2>&1)"
echo "$out"
echo "$out" | grep -qx "Test completed successfully" && exit 0 || exit 1
